// ==== sim/ip_mux_stim.txt ====
# sel en mid_sel, then per port 0..3: ip_len proto src dst (hex)
# then payload length (dec), first byte, user on last beat, back-pressure
0 1 2 0040 06 0a000001 0a000101 0041 11 0a000002 0a000102 0042 06 0a000003 0a000103 0043 11 0a000004 0a000104 5 10 1 0
1 1 0 0100 11 c0a80001 c0a80101 0101 06 c0a80002 c0a80102 0102 11 c0a80003 c0a80103 0103 06 c0a80004 c0a80104 8 20 0 0
2 1 3 0200 01 ac100001 ac100101 0201 02 ac100002 ac100102 0202 03 ac100003 ac100103 0203 04 ac100004 ac100104 3 fe 1 1
3 1 1 0300 06 01020304 05060708 0301 06 11121314 15161718 0302 06 21222324 25262728 0303 06 31323334 35363738 12 40 0 1
0 0 1 0050 11 0b000001 0b000101 0051 11 0b000002 0b000102 0052 11 0b000003 0b000103 0053 11 0b000004 0b000104 4 80 1 0
1 1 3 0060 06 0c000001 0c000101 0061 06 0c000002 0c000102 0062 06 0c000003 0c000103 0063 06 0c000004 0c000104 1 99 1 1
2 0 0 0070 32 0d000001 0d000101 0071 32 0d000002 0d000102 0072 32 0d000003 0d000103 0073 32 0d000004 0d000104 6 a0 0 1
3 1 2 0080 2f 0e000001 0e000101 0081 2f 0e000002 0e000102 0082 2f 0e000003 0e000103 0083 2f 0e000004 0e000104 16 f0 1 1
0 1 3 0090 06 0f000001 0f000101 0091 06 0f000002 0f000102 0092 06 0f000003 0f000103 0093 06 0f000004 0f000104 10 00 0 1
2 1 1 00a0 11 10000001 10000101 00a1 11 10000002 10000102 00a2 11 10000003 10000103 00a3 11 10000004 10000104 2 7f 1 0
1 1 0 00b0 06 11000001 11000101 00b1 06 11000002 11000102 00b2 06 11000003 11000103 00b3 06 11000004 11000104 9 30 0 1
3 1 0 00c0 01 12000001 12000101 00c1 01 12000002 12000102 00c2 01 12000003 12000103 00c3 01 12000004 12000104 7 c8 1 1

// ==== ip_mux_top.f ====
rtl/ip_mux_pkg.sv
rtl/payload_if.sv
rtl/frame_fsm.sv
rtl/hdr_reg.sv
rtl/payload_select.sv
rtl/skid_buffer.sv
rtl/ip_mux_top.sv
sim/ip_mux_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= ip_mux_tb
FILELIST  ?= ip_mux_top.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/ip_mux_tb.sv ====
// testbench for ip_mux_top with stimulus file reader, port drivers,
// output monitor and check tasks
`timescale 1ns/1ps

module ip_mux_tb;

    localparam int          NUM_PORTS = 4;
    localparam int          DATA_W    = 8;
    localparam int          HDR_W     = ip_mux_pkg::HDR_W;
    localparam int          CLK_NS    = 4;
    localparam logic [31:0] SEED      = 32'h29855589;
    localparam int          MAX_FR    = 32;
    localparam int          EN_WAIT   = 10;

    logic                              clk = 1'b0;
    logic                              rst;
    logic [NUM_PORTS-1:0]              in_hdr_valid;
    logic [NUM_PORTS-1:0]              in_hdr_ready;
    logic [NUM_PORTS-1:0][HDR_W-1:0]   in_hdr;
    logic [NUM_PORTS-1:0][DATA_W-1:0]  in_payload_tdata;
    logic [NUM_PORTS-1:0]              in_payload_tvalid;
    logic [NUM_PORTS-1:0]              in_payload_tready;
    logic [NUM_PORTS-1:0]              in_payload_tlast;
    logic [NUM_PORTS-1:0]              in_payload_tuser;
    logic                              out_hdr_valid;
    logic                              out_hdr_ready;
    logic [HDR_W-1:0]                  out_hdr;
    logic [DATA_W-1:0]                 out_payload_tdata;
    logic                              out_payload_tvalid;
    logic                              out_payload_tready;
    logic                              out_payload_tlast;
    logic                              out_payload_tuser;
    logic                              enable;
    logic [$clog2(NUM_PORTS)-1:0]      select;

    // one entry per frame line
    int          f_sel [MAX_FR];
    int          f_en [MAX_FR];
    int          f_mid [MAX_FR];
    logic [15:0] f_len [MAX_FR][NUM_PORTS];
    logic [7:0]  f_proto [MAX_FR][NUM_PORTS];
    logic [31:0] f_src [MAX_FR][NUM_PORTS];
    logic [31:0] f_dst [MAX_FR][NUM_PORTS];
    int          f_plen [MAX_FR];
    int          f_first [MAX_FR];
    int          f_user [MAX_FR];
    int          f_bp [MAX_FR];
    int          num_frames;
    int          hdr_errs;
    int          beat_errs;
    int          ctrl_errs;
    int          cur_sel;
    bit          started;

    ip_mux_top #(.NUM_PORTS(NUM_PORTS), .DATA_W(DATA_W)) u_ip_mux_top (.*);

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [HDR_W-1:0] build_hdr(input logic [15:0] len,
                                                   input logic [7:0] proto,
                                                   input logic [31:0] src,
                                                   input logic [31:0] dst);
        logic [HDR_W-1:0] h;
        h = '0;
        h[ip_mux_pkg::HDR_LEN_LSB +: ip_mux_pkg::IP_LEN_W]     = len;
        h[ip_mux_pkg::HDR_PROTO_LSB +: ip_mux_pkg::IP_PROTO_W] = proto;
        h[ip_mux_pkg::HDR_SRC_LSB +: ip_mux_pkg::IP_ADDR_W]    = src;
        h[ip_mux_pkg::HDR_DST_LSB +: ip_mux_pkg::IP_ADDR_W]    = dst;
        return h;
    endfunction

    task automatic check_hdr(input logic [HDR_W-1:0] got, input logic [HDR_W-1:0] exp);
        if (got !== exp) begin
            hdr_errs++;
            $display("[ERROR] %0t ns: header got len %h proto %h src %h dst %h", $time,
                     got[ip_mux_pkg::HDR_LEN_LSB +: ip_mux_pkg::IP_LEN_W],
                     got[ip_mux_pkg::HDR_PROTO_LSB +: ip_mux_pkg::IP_PROTO_W],
                     got[ip_mux_pkg::HDR_SRC_LSB +: ip_mux_pkg::IP_ADDR_W],
                     got[ip_mux_pkg::HDR_DST_LSB +: ip_mux_pkg::IP_ADDR_W]);
            $display("[ERROR] %0t ns: header expected %h", $time, exp);
        end
    endtask

    task automatic check_beat(input logic [DATA_W-1:0] got_d, input logic got_l,
                              input logic got_u, input logic [DATA_W-1:0] exp_d,
                              input logic exp_l, input logic exp_u);
        if (got_d !== exp_d || got_l !== exp_l || got_u !== exp_u) begin
            beat_errs++;
            $display("[ERROR] %0t ns: beat got %h/%b/%b expected %h/%b/%b", $time,
                     got_d, got_l, got_u, exp_d, exp_l, exp_u);
        end
    endtask

    // only the latched port may ever see a ready
    always @(posedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if ((!started || p != cur_sel) && (in_hdr_ready[p] || in_payload_tready[p])) begin
                    ctrl_errs++;
                    $display("[ERROR] %0t ns: ready seen on port %0d", $time, p);
                end
            end
            if (!started && (out_hdr_valid || out_payload_tvalid)) begin
                ctrl_errs++;
                $display("[ERROR] %0t ns: output valid before first frame", $time);
            end
        end
    end

    // each port drops its header valid once it sees ready
    always @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_hdr_valid[p] && in_hdr_ready[p]) begin
                in_hdr_valid[p] <= 1'b0;
            end
        end
    end

    task automatic drive_payload(input int p, input int len, input int first, input int user);
        for (int i = 0; i < len; i++) begin
            in_payload_tvalid[p] <= 1'b1;
            in_payload_tdata[p]  <= DATA_W'(first + i);
            in_payload_tlast[p]  <= (i == len - 1);
            in_payload_tuser[p]  <= (i == len - 1) && (user != 0);
            do @(posedge clk); while (!in_payload_tready[p]);
        end
        in_payload_tvalid[p] <= 1'b0;
        in_payload_tlast[p]  <= 1'b0;
    endtask

    task automatic collect_payload(input int len, input int first, input int user, input int bp);
        int n;
        n = 0;
        while (n < len) begin
            @(posedge clk);
            if (out_payload_tvalid && out_payload_tready) begin
                check_beat(out_payload_tdata, out_payload_tlast, out_payload_tuser,
                           DATA_W'(first + n), n == len - 1, (n == len - 1) && (user != 0));
                n++;
            end
            out_payload_tready <= (bp != 0) ? 1'($urandom % 2) : 1'b1;
        end
        out_payload_tready <= 1'b1;
    endtask

    task automatic read_stim();
        int    fd;
        int    n;
        string line;
        fd = $fopen("sim/ip_mux_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file sim/ip_mux_stim.txt");
        end else begin
            while (!$feof(fd) && num_frames < MAX_FR) begin
                n = $fgets(line, fd);
                if (n > 4 && line[0] != "#") begin
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h %h",
                        f_sel[num_frames], f_en[num_frames], f_mid[num_frames],
                        f_len[num_frames][0], f_proto[num_frames][0],
                        f_src[num_frames][0], f_dst[num_frames][0],
                        f_len[num_frames][1], f_proto[num_frames][1],
                        f_src[num_frames][1], f_dst[num_frames][1],
                        f_len[num_frames][2], f_proto[num_frames][2],
                        f_src[num_frames][2], f_dst[num_frames][2],
                        f_len[num_frames][3], f_proto[num_frames][3],
                        f_src[num_frames][3], f_dst[num_frames][3],
                        f_plen[num_frames], f_first[num_frames],
                        f_user[num_frames], f_bp[num_frames]);
                    if (n == 23) begin
                        num_frames++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_frames();
        int               s;
        logic [HDR_W-1:0] exp_hdr;
        for (int f = 0; f < num_frames; f++) begin
            s = f_sel[f];
            exp_hdr = build_hdr(f_len[f][s], f_proto[f][s], f_src[f][s], f_dst[f][s]);
            cur_sel = s;
            started = 1'b1;
            select <= 2'(s);
            enable <= (f_en[f] != 0);
            out_payload_tready <= 1'b1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                in_hdr[p] <= build_hdr(f_len[f][p], f_proto[f][p], f_src[f][p], f_dst[f][p]);
                in_hdr_valid[p] <= 1'b1;
            end
            if (f_en[f] == 0) begin
                repeat (EN_WAIT) begin
                    @(posedge clk);
                    if (out_hdr_valid) begin
                        ctrl_errs++;
                        $display("[ERROR] %0t ns: header valid while disabled", $time);
                    end
                end
                enable <= 1'b1;
            end
            fork
                begin
                    do @(posedge clk); while (!out_hdr_valid);
                    check_hdr(out_hdr, exp_hdr);
                    out_hdr_ready <= 1'b1;
                    @(posedge clk);
                    out_hdr_ready <= 1'b0;
                end
                begin
                    // select moves once the frame is latched
                    do @(posedge clk); while (!in_hdr_ready[s]);
                    select <= 2'(f_mid[f]);
                end
                begin
                    drive_payload(s, f_plen[f], f_first[f], f_user[f]);
                    // the other ports stop offering headers when the frame ends
                    in_hdr_valid <= '0;
                end
                collect_payload(f_plen[f], f_first[f], f_user[f], f_bp[f]);
            join
            repeat (3) begin
                @(posedge clk);
                if (out_payload_tvalid) begin
                    beat_errs++;
                    $display("[ERROR] %0t ns: extra output beat", $time);
                end
            end
        end
    endtask

    initial begin
        int dummy;
        int limit;
        dummy = $urandom(SEED);
        rst = 1'b1;
        in_hdr_valid = '0;
        in_hdr = '0;
        in_payload_tdata = '0;
        in_payload_tvalid = '0;
        in_payload_tlast = '0;
        in_payload_tuser = '0;
        out_hdr_ready = 1'b0;
        out_payload_tready = 1'b0;
        enable = 1'b0;
        select = '0;
        num_frames = 0;
        hdr_errs = 0;
        beat_errs = 0;
        ctrl_errs = 0;
        cur_sel = 0;
        started = 1'b0;
        read_stim();
        if (num_frames > 0) begin
            limit = 0;
            for (int f = 0; f < num_frames; f++) begin
                limit += f_plen[f] + 20;
            end
            limit = limit * CLK_NS * 4;
            fork
                begin
                    #(limit * 1ns);
                    $display("simulation timed out after %0d ns", limit);
                    $display("Done: errors found");
                    $finish;
                end
            join_none
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            repeat (5) @(posedge clk);
            run_frames();
        end else begin
            $display("no frame lines were read from the stimulus file");
        end
        $display("frames %0d, header errors %0d, beat errors %0d, control errors %0d",
                 num_frames, hdr_errs, beat_errs, ctrl_errs);
        if (hdr_errs + beat_errs + ctrl_errs == 0 && num_frames > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== rtl/ip_mux_top.sv ====
// ip frame multiplexer top level that merges four input ports onto one output
`timescale 1ns/1ps

module ip_mux_top #(
    parameter int NUM_PORTS = 4,
    parameter int DATA_W    = 8
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [NUM_PORTS-1:0]                        in_hdr_valid,
    output logic [NUM_PORTS-1:0]                        in_hdr_ready,
    input  logic [NUM_PORTS-1:0][ip_mux_pkg::HDR_W-1:0] in_hdr,
    input  logic [NUM_PORTS-1:0][DATA_W-1:0]            in_payload_tdata,
    input  logic [NUM_PORTS-1:0]                        in_payload_tvalid,
    output logic [NUM_PORTS-1:0]                        in_payload_tready,
    input  logic [NUM_PORTS-1:0]                        in_payload_tlast,
    input  logic [NUM_PORTS-1:0]                        in_payload_tuser,
    output logic                                        out_hdr_valid,
    input  logic                                        out_hdr_ready,
    output logic [ip_mux_pkg::HDR_W-1:0]                out_hdr,
    output logic [DATA_W-1:0]                           out_payload_tdata,
    output logic                                        out_payload_tvalid,
    input  logic                                        out_payload_tready,
    output logic                                        out_payload_tlast,
    output logic                                        out_payload_tuser,
    input  logic                                        enable,
    input  logic [$clog2(NUM_PORTS)-1:0]                select
);

    logic [$clog2(NUM_PORTS)-1:0] sel_next;
    logic                         frame_next;
    logic                         hdr_load;
    logic                         beat_accept;
    logic                         beat_last;

    payload_if #(.DATA_W(DATA_W)) pl_if ();

    frame_fsm #(.NUM_PORTS(NUM_PORTS)) u_frame_fsm (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .select       (select),
        .in_hdr_valid (in_hdr_valid),
        .out_hdr_valid(out_hdr_valid),
        .beat_accept  (beat_accept),
        .beat_last    (beat_last),
        .in_hdr_ready (in_hdr_ready),
        .sel_next     (sel_next),
        .frame_next   (frame_next),
        .hdr_load     (hdr_load)
    );

    hdr_reg #(.NUM_PORTS(NUM_PORTS)) u_hdr_reg (
        .clk          (clk),
        .rst          (rst),
        .in_hdr       (in_hdr),
        .sel_next     (sel_next),
        .hdr_load     (hdr_load),
        .out_hdr_ready(out_hdr_ready),
        .out_hdr      (out_hdr),
        .out_hdr_valid(out_hdr_valid)
    );

    payload_select #(.NUM_PORTS(NUM_PORTS), .DATA_W(DATA_W)) u_payload_select (
        .clk              (clk),
        .rst              (rst),
        .in_payload_tdata (in_payload_tdata),
        .in_payload_tvalid(in_payload_tvalid),
        .in_payload_tready(in_payload_tready),
        .in_payload_tlast (in_payload_tlast),
        .in_payload_tuser (in_payload_tuser),
        .sel_next         (sel_next),
        .frame_next       (frame_next),
        .beat_accept      (beat_accept),
        .beat_last        (beat_last),
        .pl               (pl_if.src)
    );

    skid_buffer #(.DATA_W(DATA_W)) u_skid_buffer (
        .clk               (clk),
        .rst               (rst),
        .pl                (pl_if.snk),
        .out_payload_tdata (out_payload_tdata),
        .out_payload_tvalid(out_payload_tvalid),
        .out_payload_tready(out_payload_tready),
        .out_payload_tlast (out_payload_tlast),
        .out_payload_tuser (out_payload_tuser)
    );

endmodule

// ==== rtl/skid_buffer.sv ====
// registered payload output with one temporary entry to absorb a stall
`timescale 1ns/1ps

module skid_buffer #(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    payload_if.snk            pl,
    output logic [DATA_W-1:0] out_payload_tdata,
    output logic              out_payload_tvalid,
    input  logic              out_payload_tready,
    output logic              out_payload_tlast,
    output logic              out_payload_tuser
);

    logic              ready_reg;
    logic [DATA_W-1:0] temp_tdata;
    logic              temp_tvalid;
    logic              temp_tlast;
    logic              temp_tuser;
    logic              load_out;
    logic              load_temp;
    logic              move_temp;

    // room next cycle if the output drains, both are empty, or temp is empty and nothing arrives
    assign pl.ready_early = out_payload_tready ||
                            (!temp_tvalid && !out_payload_tvalid) ||
                            (!temp_tvalid && !pl.tvalid);

    assign load_out  = ready_reg && (out_payload_tready || !out_payload_tvalid);
    assign load_temp = ready_reg && !out_payload_tready && out_payload_tvalid;
    assign move_temp = !ready_reg && out_payload_tready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg          <= 1'b0;
            out_payload_tvalid <= 1'b0;
            temp_tvalid        <= 1'b0;
        end else begin
            ready_reg <= pl.ready_early;
            if (load_out) begin
                out_payload_tvalid <= pl.tvalid;
            end else if (move_temp) begin
                out_payload_tvalid <= temp_tvalid;
                temp_tvalid        <= 1'b0;
            end
            if (load_temp) begin
                temp_tvalid <= pl.tvalid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_payload_tdata <= pl.tdata;
            out_payload_tlast <= pl.tlast;
            out_payload_tuser <= pl.tuser;
        end else if (move_temp) begin
            out_payload_tdata <= temp_tdata;
            out_payload_tlast <= temp_tlast;
            out_payload_tuser <= temp_tuser;
        end
        if (load_temp) begin
            temp_tdata <= pl.tdata;
            temp_tlast <= pl.tlast;
            temp_tuser <= pl.tuser;
        end
    end

endmodule

// ==== rtl/payload_select.sv ====
// payload input mux and registered per-port payload ready
`timescale 1ns/1ps

module payload_select #(
    parameter int NUM_PORTS = 4,
    parameter int DATA_W    = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [NUM_PORTS-1:0][DATA_W-1:0] in_payload_tdata,
    input  logic [NUM_PORTS-1:0]             in_payload_tvalid,
    output logic [NUM_PORTS-1:0]             in_payload_tready,
    input  logic [NUM_PORTS-1:0]             in_payload_tlast,
    input  logic [NUM_PORTS-1:0]             in_payload_tuser,
    input  logic [$clog2(NUM_PORTS)-1:0]     sel_next,
    input  logic                             frame_next,
    output logic                             beat_accept,
    output logic                             beat_last,
    payload_if.src                           pl
);

    localparam int SEL_W = $clog2(NUM_PORTS);

    logic [SEL_W-1:0] sel_reg;
    logic             frame_reg;

    // only a beat taken from the current port while in frame goes on
    assign beat_accept = frame_reg && in_payload_tvalid[sel_reg] && in_payload_tready[sel_reg];
    assign beat_last   = in_payload_tlast[sel_reg];

    assign pl.tdata  = in_payload_tdata[sel_reg];
    assign pl.tvalid = beat_accept;
    assign pl.tlast  = in_payload_tlast[sel_reg];
    assign pl.tuser  = in_payload_tuser[sel_reg];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_reg           <= '0;
            frame_reg         <= 1'b0;
            in_payload_tready <= '0;
        end else begin
            sel_reg   <= sel_next;
            frame_reg <= frame_next;
            for (int i = 0; i < NUM_PORTS; i++) begin
                in_payload_tready[i] <= frame_next && pl.ready_early &&
                                        (sel_next == SEL_W'(i));
            end
        end
    end

endmodule

// ==== rtl/hdr_reg.sv ====
// input header mux and output header register with its valid flag
`timescale 1ns/1ps

module hdr_reg #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [NUM_PORTS-1:0][ip_mux_pkg::HDR_W-1:0] in_hdr,
    input  logic [$clog2(NUM_PORTS)-1:0]                sel_next,
    input  logic                                        hdr_load,
    input  logic                                        out_hdr_ready,
    output logic [ip_mux_pkg::HDR_W-1:0]                out_hdr,
    output logic                                        out_hdr_valid
);

    logic [ip_mux_pkg::HDR_W-1:0] sel_hdr;

    assign sel_hdr = in_hdr[sel_next];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            out_hdr_valid <= 1'b1;
        end else if (out_hdr_ready) begin
            out_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            out_hdr <= sel_hdr;
        end
    end

endmodule

// ==== rtl/frame_fsm.sv ====
// idle/frame state machine with latched select and per-port header ready
`timescale 1ns/1ps

module frame_fsm #(
    parameter int NUM_PORTS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enable,
    input  logic [$clog2(NUM_PORTS)-1:0] select,
    input  logic [NUM_PORTS-1:0]         in_hdr_valid,
    input  logic                         out_hdr_valid,
    input  logic                         beat_accept,
    input  logic                         beat_last,
    output logic [NUM_PORTS-1:0]         in_hdr_ready,
    output logic [$clog2(NUM_PORTS)-1:0] sel_next,
    output logic                         frame_next,
    output logic                         hdr_load
);

    localparam int   SEL_W = $clog2(NUM_PORTS);
    localparam logic IDLE  = 1'b0;
    localparam logic FRAME = 1'b1;

    logic             state_reg;
    logic             state_next;
    logic [SEL_W-1:0] select_reg;
    logic             start;

    // previous header must have left the output register first
    assign start = (state_reg == IDLE) && enable && in_hdr_valid[select] && !out_hdr_valid;

    always_comb begin
        state_next = state_reg;
        if (state_reg == FRAME) begin
            if (beat_accept && beat_last) begin
                state_next = IDLE;
            end
        end else if (start) begin
            state_next = FRAME;
        end
    end

    assign frame_next = (state_next == FRAME);
    assign sel_next   = start ? select : select_reg;
    assign hdr_load   = start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_reg    <= IDLE;
            select_reg   <= '0;
            in_hdr_ready <= '0;
        end else begin
            state_reg  <= state_next;
            select_reg <= sel_next;
            // held until the port drops its header valid
            for (int i = 0; i < NUM_PORTS; i++) begin
                in_hdr_ready[i] <= (in_hdr_ready[i] && in_hdr_valid[i]) ||
                                   (start && (select == SEL_W'(i)));
            end
        end
    end

endmodule

// ==== rtl/payload_if.sv ====
// internal payload stream from the port selector to the output skid buffer
`timescale 1ns/1ps

interface payload_if #(
    parameter int DATA_W = 8
);

    logic [DATA_W-1:0] tdata;
    logic              tvalid;
    logic              tlast;
    logic              tuser;
    // sink can take a beat in the next cycle
    logic              ready_early;

    modport src (output tdata, output tvalid, output tlast, output tuser, input ready_early);

    modport snk (input tdata, input tvalid, input tlast, input tuser, output ready_early);

endinterface

// ==== rtl/ip_mux_pkg.sv ====
// ip header field widths and the bit layout of the flat header word
package ip_mux_pkg;

    localparam int IP_LEN_W   = 16;
    localparam int IP_PROTO_W = 8;
    localparam int IP_ADDR_W  = 32;

    // length, protocol, source, destination from msb down
    localparam int HDR_W = IP_LEN_W + IP_PROTO_W + 2 * IP_ADDR_W;

    localparam int HDR_DST_LSB   = 0;
    localparam int HDR_SRC_LSB   = HDR_DST_LSB + IP_ADDR_W;
    localparam int HDR_PROTO_LSB = HDR_SRC_LSB + IP_ADDR_W;
    localparam int HDR_LEN_LSB   = HDR_PROTO_LSB + IP_PROTO_W;

endpackage
